// ==== source/csr_consts.svh ====
/*
 * CSR block constants
 * Field widths, register address map, reset values and version
 */
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// ----------------------------------------
// Widths
// ----------------------------------------
`define CSR_ADDR_W   8   // Host address bus
`define CSR_DATA_W   16  // Host data bus
`define PULSER_LEN_W 8   // Pulser interval, in pulser ticks
`define DAC_DATA_W   10
`define ACQ_LINES_W  5
`define GAIN_PTR_W   5
`define GAIN_N       32  // Gain table depth
`define LED_N        3
`define JUMPER_N     3

// ----------------------------------------
// Address map
// ----------------------------------------
`define INITDEL_ADDR  8'h00
`define PONW_ADDR     8'h01
`define POFFW_ADDR    8'h02
`define INTERW_ADDR   8'h03
`define DRMODE_ADDR   8'h04
`define DACOUT_ADDR   8'h05
`define ACQSTART_ADDR 8'h06
`define ACQDONE_ADDR  8'h07
`define ACQBUSY_ADDR  8'h08
`define NBLINES_ADDR  8'h09
`define LED1_ADDR     8'h0A
`define LED2_ADDR     8'h0B
`define LED3_ADDR     8'h0C
`define JUMPER_ADDR   8'h0D
`define VERSION_ADDR  8'h0F
`define GAIN_BASE     8'h20 // 32 entry window, 0x20..0x3F

// ----------------------------------------
// Reset values
// ----------------------------------------
`define INITDEL_RST 8'h10
`define PONW_RST    8'h08
`define POFFW_RST   8'h08
`define INTERW_RST  8'h04
`define DRMODE_RST  1'b0
`define DACOUT_RST  10'h200 // Mid scale
`define NBLINES_RST 5'd8
`define LED1_RST    1'b0
`define LED2_RST    1'b0
`define LED3_RST    1'b1
`define VERSION_VAL 8'h12

`endif

// ==== source/csr_pkg.sv ====
/*
 * CSR package
 * Field types and the register select encoding
 */
`include "csr_consts.svh"

package csr_pkg;

    // Host bus fields
    typedef logic [`CSR_ADDR_W-1:0]   csr_addr_t;
    typedef logic [`CSR_DATA_W-1:0]   csr_data_t;

    // Application fields
    typedef logic [`PULSER_LEN_W-1:0] pulser_len_t; // Pulser ticks
    typedef logic [`DAC_DATA_W-1:0]   dac_data_t;   // DAC code
    typedef logic [`GAIN_PTR_W-1:0]   gain_ptr_t;   // Gain table index
    typedef logic [`ACQ_LINES_W-1:0]  acq_lines_t;

    // One value per register, plus the gain window and unmapped space
    typedef enum logic [4:0] {
        SEL_INITDEL,
        SEL_PONW,
        SEL_POFFW,
        SEL_INTERW,
        SEL_DRMODE,
        SEL_DACOUT,
        SEL_ACQSTART,
        SEL_ACQDONE,
        SEL_ACQBUSY,
        SEL_NBLINES,
        SEL_LED1,
        SEL_LED2,
        SEL_LED3,
        SEL_JUMPER,
        SEL_VERSION,
        SEL_GAIN,   // Any entry of the gain table
        SEL_NONE    // Unmapped, reads zero
    } reg_sel_e;

endpackage

// ==== source/csr_req_if.sv ====
/*
 * Decoded host request
 * One registered write or read request, shared by bank and gain table
 */
interface csr_req_if;
    import csr_pkg::*;

    logic      wen;      // Write strobe, one cycle
    logic      ren;      // Read strobe, one cycle
    reg_sel_e  sel;      // Target register
    csr_data_t wdata;
    gain_ptr_t gain_idx; // Entry, meaningful for SEL_GAIN only

    modport decoder (output wen, ren, sel, wdata, gain_idx);

    modport bank (input wen, ren, sel, wdata);

    // Gain table side
    modport gain (input wen, ren, sel, wdata, gain_idx);

endinterface

// ==== source/csr_addr_decoder.sv ====
/*
 * CSR address decoder
 * Registers the host strobes and maps the address to a register select
 */
`include "csr_consts.svh"

module csr_addr_decoder (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_addr_t csr_addr,
    input  logic               csr_wen,
    input  csr_pkg::csr_data_t csr_wdata,
    input  logic               csr_ren,
    csr_req_if.decoder         req
);
    import csr_pkg::*;

    reg_sel_e dec_sel; // Combinational decode of csr_addr

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    always_comb begin
        case (csr_addr)
            `INITDEL_ADDR:  dec_sel = SEL_INITDEL;
            `PONW_ADDR:     dec_sel = SEL_PONW;
            `POFFW_ADDR:    dec_sel = SEL_POFFW;
            `INTERW_ADDR:   dec_sel = SEL_INTERW;
            `DRMODE_ADDR:   dec_sel = SEL_DRMODE;
            `DACOUT_ADDR:   dec_sel = SEL_DACOUT;
            `ACQSTART_ADDR: dec_sel = SEL_ACQSTART;
            `ACQDONE_ADDR:  dec_sel = SEL_ACQDONE;
            `ACQBUSY_ADDR:  dec_sel = SEL_ACQBUSY;
            `NBLINES_ADDR:  dec_sel = SEL_NBLINES;
            `LED1_ADDR:     dec_sel = SEL_LED1;
            `LED2_ADDR:     dec_sel = SEL_LED2;
            `LED3_ADDR:     dec_sel = SEL_LED3;
            `JUMPER_ADDR:   dec_sel = SEL_JUMPER;
            `VERSION_ADDR:  dec_sel = SEL_VERSION;
            default: begin
                // Gain window when the upper bits match the base
                if ((csr_addr >> `GAIN_PTR_W) == (`GAIN_BASE >> `GAIN_PTR_W))
                    dec_sel = SEL_GAIN;
                else
                    dec_sel = SEL_NONE;
            end
        endcase
    end

    // ----------------------------------------
    // Request register, edge 1
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req.wen <= 1'b0;
            req.ren <= 1'b0;
            req.sel <= SEL_NONE;
        end else begin
            req.wen <= csr_wen;
            req.ren <= csr_ren;
            req.sel <= dec_sel;
        end
    end

    // Payload is meaningful only with a strobe
    always_ff @(posedge clk) begin
        req.wdata    <= csr_wdata;
        req.gain_idx <= gain_ptr_t'(csr_addr); // Low address bits pick the entry
    end

    // Host issues one request at a time
    a_no_wen_and_ren: assert property (@(posedge clk) disable iff (rst)
        !(csr_wen && csr_ren));

endmodule

// ==== source/csr_reg_bank.sv ====
/*
 * CSR register bank
 * Pulser, DAC idle, acquisition and LED registers, plus status read data
 */
`include "csr_consts.svh"

module csr_reg_bank (
    input  logic                 clk,
    input  logic                 rst,
    csr_req_if.bank              req,
    input  logic                 acq_start_ext,    // External start strobe
    input  logic                 acq_done,
    input  logic                 acq_busy,
    input  logic [`JUMPER_N-1:0] jumper,
    output csr_pkg::pulser_len_t pulser_init_len,  // Delay before on pulse
    output csr_pkg::pulser_len_t pulser_on_len,
    output csr_pkg::pulser_len_t pulser_off_len,
    output csr_pkg::pulser_len_t pulser_inter_len, // Gap between on and off
    output logic                 pulser_drmode,    // Double rate mode
    output csr_pkg::dac_data_t   dac_idle,
    output logic                 acq_start,
    output csr_pkg::acq_lines_t  acq_lines,
    output logic [`LED_N-1:0]    led,
    output logic                 reg_rvalid,
    output csr_pkg::csr_data_t   reg_rdata
);
    import csr_pkg::*;

    logic acq_done_d; // Delayed copy for edge detect
    logic done_rise;

    // ----------------------------------------
    // Plain writable registers
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pulser_init_len  <= pulser_len_t'(`INITDEL_RST);
            pulser_on_len    <= pulser_len_t'(`PONW_RST);
            pulser_off_len   <= pulser_len_t'(`POFFW_RST);
            pulser_inter_len <= pulser_len_t'(`INTERW_RST);
            pulser_drmode    <= `DRMODE_RST;
            dac_idle         <= dac_data_t'(`DACOUT_RST);
            acq_lines        <= acq_lines_t'(`NBLINES_RST);
        end else if (req.wen) begin
            // Write data truncated to field width
            case (req.sel)
                SEL_INITDEL: pulser_init_len  <= pulser_len_t'(req.wdata);
                SEL_PONW:    pulser_on_len    <= pulser_len_t'(req.wdata);
                SEL_POFFW:   pulser_off_len   <= pulser_len_t'(req.wdata);
                SEL_INTERW:  pulser_inter_len <= pulser_len_t'(req.wdata);
                SEL_DRMODE:  pulser_drmode    <= req.wdata[0];
                SEL_DACOUT:  dac_idle         <= dac_data_t'(req.wdata);
                SEL_NBLINES: acq_lines        <= acq_lines_t'(req.wdata);
                default: ;   // Read-only or not in this bank
            endcase
        end
    end

    // ----------------------------------------
    // Acquisition start
    // ----------------------------------------
    // Pulse on a CSR write or on the external strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            acq_start <= 1'b0;
        else
            acq_start <= (req.wen && req.sel == SEL_ACQSTART) || acq_start_ext;
    end

    // ----------------------------------------
    // LEDs
    // ----------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            acq_done_d <= 1'b0;
        else
            acq_done_d <= acq_done;
    end

    assign done_rise = acq_done && !acq_done_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            led <= {`LED3_RST, `LED2_RST, `LED1_RST};
        end else begin
            // LED1 tracks acquisition, host write wins
            if (req.wen && req.sel == SEL_LED1)
                led[0] <= req.wdata[0];
            else if (acq_start)
                led[0] <= 1'b1;    // Acquisition started
            else if (done_rise)
                led[0] <= 1'b0;    // Acquisition finished
            if (req.wen && req.sel == SEL_LED2)
                led[1] <= req.wdata[0];
            if (req.wen && req.sel == SEL_LED3)
                led[2] <= req.wdata[0];
        end
    end

    // ----------------------------------------
    // Read data
    // ----------------------------------------
    // Gain reads answered by the table
    assign reg_rvalid = req.ren && (req.sel != SEL_GAIN);

    always_comb begin
        case (req.sel)
            SEL_INITDEL: reg_rdata = csr_data_t'(pulser_init_len);
            SEL_PONW:    reg_rdata = csr_data_t'(pulser_on_len);
            SEL_POFFW:   reg_rdata = csr_data_t'(pulser_off_len);
            SEL_INTERW:  reg_rdata = csr_data_t'(pulser_inter_len);
            SEL_DRMODE:  reg_rdata = csr_data_t'(pulser_drmode);
            SEL_DACOUT:  reg_rdata = csr_data_t'(dac_idle);
            SEL_ACQDONE: reg_rdata = csr_data_t'(acq_done);
            SEL_ACQBUSY: reg_rdata = csr_data_t'(acq_busy);
            SEL_NBLINES: reg_rdata = csr_data_t'(acq_lines);
            SEL_LED1:    reg_rdata = csr_data_t'(led[0]);
            SEL_LED2:    reg_rdata = csr_data_t'(led[1]);
            SEL_LED3:    reg_rdata = csr_data_t'(led[2]);
            SEL_JUMPER:  reg_rdata = csr_data_t'(jumper);
            SEL_VERSION: reg_rdata = csr_data_t'(`VERSION_VAL);
            default:     reg_rdata = '0; // ACQSTART and unmapped
        endcase
    end

    // Start is a single-cycle event for the acquisition engine
    a_acq_start_pulse: assert property (@(posedge clk) disable iff (rst)
        acq_start |=> !acq_start);

endmodule

// ==== source/dac_gain_table.sv ====
/*
 * DAC gain table
 * 32-entry gain memory, one read port shared by datapath and host
 */
`include "csr_consts.svh"

module dac_gain_table (
    input  logic               clk,
    input  logic               rst,
    csr_req_if.gain            req,
    input  csr_pkg::gain_ptr_t dac_gain_ptr, // Datapath lookup index
    output csr_pkg::dac_data_t dac_gain,
    output logic               gain_rvalid,
    output csr_pkg::dac_data_t gain_rdata
);
    import csr_pkg::*;

    dac_data_t mem [`GAIN_N]; // Undefined until written

    logic      wr_en;
    logic      rd_req;    // Host read of the gain window
    gain_ptr_t raddr;
    dac_data_t rdata_q;
    logic      rvalid_p1; // Address captured
    logic      rvalid_p2; // Data captured

    assign wr_en  = req.wen && (req.sel == SEL_GAIN);
    assign rd_req = req.ren && (req.sel == SEL_GAIN);

    // ----------------------------------------
    // Write port, edge 2
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[req.gain_idx] <= dac_data_t'(req.wdata);
    end

    // ----------------------------------------
    // Shared read port
    // ----------------------------------------
    // Host read borrows the port for one address capture
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            raddr     <= '0;
            rvalid_p1 <= 1'b0;
            rvalid_p2 <= 1'b0;
        end else begin
            raddr     <= rd_req ? req.gain_idx : dac_gain_ptr;
            rvalid_p1 <= rd_req;
            rvalid_p2 <= rvalid_p1;
        end
    end

    // Data register holds while a write is in progress
    always_ff @(posedge clk) begin
        if (!wr_en)
            rdata_q <= mem[raddr];
    end

    assign dac_gain    = rdata_q;
    assign gain_rdata  = rdata_q;
    assign gain_rvalid = rvalid_p2;

endmodule

// ==== source/csr_read_return.sv ====
/*
 * CSR read return
 * Merges bank and gain table responses into one registered read
 */
module csr_read_return (
    input  logic               clk,
    input  logic               rst,
    input  logic               reg_rvalid,
    input  csr_pkg::csr_data_t reg_rdata,
    input  logic               gain_rvalid,
    input  csr_pkg::dac_data_t gain_rdata,
    output logic               csr_rvalid,  // One-cycle strobe
    output csr_pkg::csr_data_t csr_rdata
);
    import csr_pkg::*;

    csr_data_t mux_rdata;

    // Only one source valid at a time
    assign mux_rdata = reg_rvalid ? reg_rdata : csr_data_t'(gain_rdata);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            csr_rvalid <= 1'b0;
        else
            csr_rvalid <= reg_rvalid || gain_rvalid;
    end

    // Response data is meaningful while csr_rvalid is high
    always_ff @(posedge clk) begin
        if (reg_rvalid || gain_rvalid)
            csr_rdata <= mux_rdata;
    end

    // Plain and gain read responses never collide
    a_single_source: assert property (@(posedge clk) disable iff (rst)
        !(reg_rvalid && gain_rvalid));

endmodule

// ==== source/csr_top.sv ====
/*
 * CSR block top
 * Host register interface for the pulser and acquisition board
 */
`include "csr_consts.svh"

module csr_top (
    input  logic                 clk,
    input  logic                 rst,
    // Host bus
    input  csr_pkg::csr_addr_t   csr_addr,
    input  logic                 csr_wen,
    input  csr_pkg::csr_data_t   csr_wdata,
    input  logic                 csr_ren,
    output logic                 csr_rvalid,
    output csr_pkg::csr_data_t   csr_rdata,
    // Pulser
    output csr_pkg::pulser_len_t pulser_init_len,
    output csr_pkg::pulser_len_t pulser_on_len,
    output csr_pkg::pulser_len_t pulser_off_len,
    output csr_pkg::pulser_len_t pulser_inter_len,
    output logic                 pulser_drmode,
    // DAC
    output csr_pkg::dac_data_t   dac_idle,
    output csr_pkg::dac_data_t   dac_gain,
    input  csr_pkg::gain_ptr_t   dac_gain_ptr,
    // Acquisition
    output logic                 acq_start,
    input  logic                 acq_start_ext,
    input  logic                 acq_done,
    input  logic                 acq_busy,
    output csr_pkg::acq_lines_t  acq_lines,
    // Board IO
    output logic [`LED_N-1:0]    led,
    input  logic [`JUMPER_N-1:0] jumper
);
    import csr_pkg::*;

    logic      reg_rvalid;
    csr_data_t reg_rdata;
    logic      gain_rvalid;
    dac_data_t gain_rdata;

    csr_req_if req ();

    csr_addr_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .csr_addr  (csr_addr),
        .csr_wen   (csr_wen),
        .csr_wdata (csr_wdata),
        .csr_ren   (csr_ren),
        .req       (req.decoder)
    );

    csr_reg_bank u_bank (
        .clk              (clk),
        .rst              (rst),
        .req              (req.bank),
        .acq_start_ext    (acq_start_ext),
        .acq_done         (acq_done),
        .acq_busy         (acq_busy),
        .jumper           (jumper),
        .pulser_init_len  (pulser_init_len),
        .pulser_on_len    (pulser_on_len),
        .pulser_off_len   (pulser_off_len),
        .pulser_inter_len (pulser_inter_len),
        .pulser_drmode    (pulser_drmode),
        .dac_idle         (dac_idle),
        .acq_start        (acq_start),
        .acq_lines        (acq_lines),
        .led              (led),
        .reg_rvalid       (reg_rvalid),
        .reg_rdata        (reg_rdata)
    );

    dac_gain_table u_gain_table (
        .clk          (clk),
        .rst          (rst),
        .req          (req.gain),
        .dac_gain_ptr (dac_gain_ptr),
        .dac_gain     (dac_gain),
        .gain_rvalid  (gain_rvalid),
        .gain_rdata   (gain_rdata)
    );

    csr_read_return u_read_return (
        .clk         (clk),
        .rst         (rst),
        .reg_rvalid  (reg_rvalid),
        .reg_rdata   (reg_rdata),
        .gain_rvalid (gain_rvalid),
        .gain_rdata  (gain_rdata),
        .csr_rvalid  (csr_rvalid),
        .csr_rdata   (csr_rdata)
    );

endmodule

// ==== verif/csr_tb_table.svh ====
/*
 * CSR testbench stimulus table
 * Reset values, write and read back, gain table, acquisition and LEDs
 */
`ifndef CSR_TB_TABLE_SVH
`define CSR_TB_TABLE_SVH

// Columns: operation, address, write data or status level, expected read value
localparam int ROWS = 55;

localparam row_t ROW_TABLE [ROWS] = '{
    // Reset values, then unmapped space
    '{OP_RD,   `INITDEL_ADDR,  17'h0,     `INITDEL_RST},
    '{OP_RD,   `PONW_ADDR,     17'h0,     `PONW_RST},
    '{OP_RD,   `POFFW_ADDR,    17'h0,     `POFFW_RST},
    '{OP_RD,   `INTERW_ADDR,   17'h0,     `INTERW_RST},
    '{OP_RD,   `DRMODE_ADDR,   17'h0,     `DRMODE_RST},
    '{OP_RD,   `DACOUT_ADDR,   17'h0,     `DACOUT_RST},
    '{OP_RD,   `ACQSTART_ADDR, 17'h0,     17'h0},
    '{OP_RD,   `ACQDONE_ADDR,  17'h0,     17'h0},
    '{OP_RD,   `ACQBUSY_ADDR,  17'h0,     17'h0},
    '{OP_RD,   `NBLINES_ADDR,  17'h0,     `NBLINES_RST},
    '{OP_RD,   `LED1_ADDR,     17'h0,     `LED1_RST},
    '{OP_RD,   `LED2_ADDR,     17'h0,     `LED2_RST},
    '{OP_RD,   `LED3_ADDR,     17'h0,     `LED3_RST},
    '{OP_RD,   `JUMPER_ADDR,   17'h0,     17'h0},
    '{OP_RD,   `VERSION_ADDR,  17'h0,     `VERSION_VAL},
    '{OP_RD,   8'h0E,          17'h0,     17'h0},      // Hole in the map
    '{OP_RD,   8'h80,          17'h0,     17'h0},      // Above the gain window
    // Random writes, then read back
    '{OP_WR,   `INITDEL_ADDR,  FROM_LFSR, 17'h0},
    '{OP_WR,   `PONW_ADDR,     FROM_LFSR, 17'h0},
    '{OP_WR,   `POFFW_ADDR,    FROM_LFSR, 17'h0},
    '{OP_WR,   `INTERW_ADDR,   FROM_LFSR, 17'h0},
    '{OP_WR,   `DRMODE_ADDR,   FROM_LFSR, 17'h0},
    '{OP_WR,   `DACOUT_ADDR,   FROM_LFSR, 17'h0},
    '{OP_WR,   `NBLINES_ADDR,  FROM_LFSR, 17'h0},
    '{OP_RD,   `INITDEL_ADDR,  17'h0,     FROM_REF},
    '{OP_RD,   `PONW_ADDR,     17'h0,     FROM_REF},
    '{OP_RD,   `POFFW_ADDR,    17'h0,     FROM_REF},
    '{OP_RD,   `INTERW_ADDR,   17'h0,     FROM_REF},
    '{OP_RD,   `DRMODE_ADDR,   17'h0,     FROM_REF},
    '{OP_RD,   `DACOUT_ADDR,   17'h0,     FROM_REF},
    '{OP_RD,   `NBLINES_ADDR,  17'h0,     FROM_REF},
    // Gain table, entry 0 first since dac_gain_ptr starts there
    '{OP_WR,   `GAIN_BASE,     FROM_LFSR, 17'h0},
    '{OP_WR,   8'h3F,          FROM_LFSR, 17'h0},
    '{OP_WR,   8'h2A,          FROM_LFSR, 17'h0},
    '{OP_RDG,  8'h3F,          17'h0,     FROM_REF},
    '{OP_RDG,  `GAIN_BASE,     17'h0,     FROM_REF},
    '{OP_RDG,  8'h2A,          17'h0,     FROM_REF},
    // Acquisition start and LED1
    '{OP_WR,   `ACQSTART_ADDR, FROM_LFSR, 17'h0},
    '{OP_RD,   `LED1_ADDR,     17'h0,     FROM_REF},
    '{OP_STAT, `ACQDONE_ADDR,  17'h1,     17'h0},      // Done edge clears LED1
    '{OP_RD,   `LED1_ADDR,     17'h0,     FROM_REF},
    '{OP_STAT, `ACQDONE_ADDR,  17'h0,     17'h0},
    '{OP_EXT,  8'h00,          17'h0,     17'h0},
    '{OP_RD,   `LED1_ADDR,     17'h0,     FROM_REF},
    '{OP_WR,   `LED1_ADDR,     17'h0,     17'h0},      // Host override
    '{OP_RD,   `LED1_ADDR,     17'h0,     FROM_REF},
    '{OP_WR,   `LED2_ADDR,     17'h3,     17'h0},
    '{OP_WR,   `LED3_ADDR,     17'hFFFE,  17'h0},
    '{OP_RD,   `LED2_ADDR,     17'h0,     FROM_REF},
    '{OP_RD,   `LED3_ADDR,     17'h0,     FROM_REF},
    // Status inputs
    '{OP_STAT, `ACQBUSY_ADDR,  17'h1,     17'h0},
    '{OP_STAT, `JUMPER_ADDR,   17'h6,     17'h0},
    '{OP_RD,   `ACQDONE_ADDR,  17'h0,     FROM_REF},
    '{OP_RD,   `ACQBUSY_ADDR,  17'h0,     FROM_REF},
    '{OP_RD,   `JUMPER_ADDR,   17'h0,     FROM_REF}
};

`endif

// ==== verif/csr_tb.sv ====
/*
 * CSR block testbench
 * Table driven host accesses checked against a register reference copy
 */
`include "csr_consts.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int PERIOD            = 40;
    localparam int READ_LATENCY      = 2;  // Plain register read
    localparam int GAIN_READ_LATENCY = 4;  // Through the gain table port
    localparam logic [16:0] FROM_LFSR = 17'h1_0000; // Take write data from LFSR
    localparam logic [16:0] FROM_REF  = 17'h1_0000; // Expect the reference copy

    typedef enum logic [2:0] {OP_WR, OP_RD, OP_RDG, OP_EXT, OP_STAT} op_e;

    typedef struct packed {
        op_e         op;
        logic [7:0]  addr;
        logic [16:0] data;    // Write data or status level
        logic [16:0] exp_val;
    } row_t;

    `include "csr_tb_table.svh"

    logic                 clk = 1'b0;
    logic                 rst;
    csr_addr_t            csr_addr;
    logic                 csr_wen;
    csr_data_t            csr_wdata;
    logic                 csr_ren;
    logic                 csr_rvalid;
    csr_data_t            csr_rdata;
    pulser_len_t          pulser_init_len;
    pulser_len_t          pulser_on_len;
    pulser_len_t          pulser_off_len;
    pulser_len_t          pulser_inter_len;
    logic                 pulser_drmode;
    dac_data_t            dac_idle;
    dac_data_t            dac_gain;
    gain_ptr_t            dac_gain_ptr;
    logic                 acq_start;
    logic                 acq_start_ext;
    logic                 acq_done;
    logic                 acq_busy;
    acq_lines_t           acq_lines;
    logic [`LED_N-1:0]    led;
    logic [`JUMPER_N-1:0] jumper;

    logic [15:0] lfsr;               // Write data generator state
    logic [15:0] ref_regs [0:255];   // Expected contents, by address

    csr_top uut (.*);

    always #(PERIOD / 2) clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            abort_run($sformatf("FAILED at time %0t: %s, got 0x%0h, expected 0x%0h",
                                $time, what, actual, expected));
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] draw_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr = lfsr_next(lfsr); // One step per bit
            w    = {w[14:0], lfsr[0]};
        end
        return w;
    endfunction

    function automatic bit in_gain_window(input logic [7:0] addr);
        return addr >= `GAIN_BASE && addr < `GAIN_BASE + `GAIN_N;
    endfunction

    // Writable bits per address (none when read-only or unmapped)
    function automatic logic [15:0] field_mask(input logic [7:0] addr);
        case (addr)
            `INITDEL_ADDR, `PONW_ADDR, `POFFW_ADDR, `INTERW_ADDR:
                return 16'((1 << `PULSER_LEN_W) - 1);
            `DRMODE_ADDR, `LED1_ADDR, `LED2_ADDR, `LED3_ADDR:
                return 16'h0001;
            `DACOUT_ADDR:  return 16'((1 << `DAC_DATA_W) - 1);
            `NBLINES_ADDR: return 16'((1 << `ACQ_LINES_W) - 1);
            default:       return in_gain_window(addr) ? 16'((1 << `DAC_DATA_W) - 1) : 16'h0;
        endcase
    endfunction

    // DUT output that mirrors a writable register
    function automatic logic [15:0] port_value(input logic [7:0] addr);
        case (addr)
            `INITDEL_ADDR: return 16'(pulser_init_len);
            `PONW_ADDR:    return 16'(pulser_on_len);
            `POFFW_ADDR:   return 16'(pulser_off_len);
            `INTERW_ADDR:  return 16'(pulser_inter_len);
            `DRMODE_ADDR:  return 16'(pulser_drmode);
            `DACOUT_ADDR:  return 16'(dac_idle);
            `NBLINES_ADDR: return 16'(acq_lines);
            `LED1_ADDR:    return 16'(led[0]);
            `LED2_ADDR:    return 16'(led[1]);
            default:       return 16'(led[2]);
        endcase
    endfunction

    // ----------------------------------------
    // Host and board operations
    // ----------------------------------------
    task automatic do_write(input logic [7:0] addr, input logic [16:0] data);
        logic [15:0] wdata;
        logic [15:0] old_val;
        logic [15:0] new_val;
        wdata   = (data == FROM_LFSR) ? draw_word() : data[15:0];
        old_val = ref_regs[addr];
        new_val = (field_mask(addr) != 0) ? (wdata & field_mask(addr)) : old_val;
        @(posedge clk);
        csr_addr  <= addr;
        csr_wdata <= wdata;
        csr_wen   <= 1'b1;
        for (int n = 1; n <= 3; n++) begin
            @(posedge clk);
            csr_wen <= 1'b0;
            @(negedge clk);
            check_equal(acq_start, addr == `ACQSTART_ADDR && n == 2, "acq_start after write");
            if (field_mask(addr) != 0 && !in_gain_window(addr))
                check_equal(port_value(addr), (n == 1) ? old_val : new_val, "port after write");
        end
        ref_regs[addr] = new_val;
        if (addr == `ACQSTART_ADDR)
            ref_regs[`LED1_ADDR] = 16'h1; // Start lights LED1
    endtask

    task automatic do_read(input logic [7:0] addr, input logic [16:0] exp_val,
                           input int latency);
        logic [15:0] expected;
        int          n;
        logic        got;
        expected = (exp_val == FROM_REF) ? ref_regs[addr] : exp_val[15:0];
        @(posedge clk);
        csr_addr <= addr;
        csr_ren  <= 1'b1;
        n   = 0;
        got = 1'b0;
        while (!got && n < 8) begin
            @(posedge clk);
            csr_ren <= 1'b0;
            @(negedge clk);
            n   = n + 1;
            got = csr_rvalid;
        end
        if (!got)
            abort_run($sformatf("Read of address 0x%0h never returned csr_rvalid", addr));
        check_equal(n, latency, "read latency in cycles");
        check_equal(csr_rdata, expected, $sformatf("read data at 0x%0h", addr));
        @(negedge clk);
        check_equal(csr_rvalid, 1'b0, "csr_rvalid longer than one cycle");
    endtask

    // Datapath lookup shows the entry two cycles after the pointer
    task automatic check_gain_port(input logic [7:0] addr);
        logic [15:0] old_val;
        old_val = ref_regs[`GAIN_BASE + dac_gain_ptr];
        @(posedge clk);
        dac_gain_ptr <= addr[`GAIN_PTR_W-1:0];
        for (int n = 1; n <= 2; n++) begin
            @(posedge clk);
            @(negedge clk);
            check_equal(dac_gain, (n == 1) ? old_val : ref_regs[addr], "dac_gain lookup");
        end
    endtask

    task automatic do_ext_start();
        @(posedge clk);
        acq_start_ext <= 1'b1;
        for (int n = 1; n <= 3; n++) begin
            @(posedge clk);
            acq_start_ext <= 1'b0;
            @(negedge clk);
            check_equal(acq_start, n == 1, "acq_start after external strobe");
        end
        ref_regs[`LED1_ADDR] = 16'h1;
    endtask

    task automatic set_status(input logic [7:0] addr, input logic [16:0] level);
        @(posedge clk);
        case (addr)
            `ACQDONE_ADDR: acq_done <= level[0];
            `ACQBUSY_ADDR: acq_busy <= level[0];
            default:       jumper   <= level[`JUMPER_N-1:0];
        endcase
        if (addr == `ACQDONE_ADDR && level[0] && !ref_regs[addr][0])
            ref_regs[`LED1_ADDR] = 16'h0; // Rising done clears LED1
        ref_regs[addr] = (addr == `JUMPER_ADDR) ? 16'(level[`JUMPER_N-1:0]) : 16'(level[0]);
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_equal(led[0], ref_regs[`LED1_ADDR], "LED1 after status change");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst           = 1'b1;
        csr_addr      = '0;
        csr_wen       = 1'b0;
        csr_wdata     = '0;
        csr_ren       = 1'b0;
        dac_gain_ptr  = '0;
        acq_start_ext = 1'b0;
        acq_done      = 1'b0;
        acq_busy      = 1'b0;
        jumper        = '0;
        lfsr          = 16'd58;
        for (int a = 0; a < 256; a++)
            ref_regs[a] = '0; // Unmapped reads zero
        ref_regs[`INITDEL_ADDR] = 16'(`INITDEL_RST);
        ref_regs[`PONW_ADDR]    = 16'(`PONW_RST);
        ref_regs[`POFFW_ADDR]   = 16'(`POFFW_RST);
        ref_regs[`INTERW_ADDR]  = 16'(`INTERW_RST);
        ref_regs[`DRMODE_ADDR]  = 16'(`DRMODE_RST);
        ref_regs[`DACOUT_ADDR]  = 16'(`DACOUT_RST);
        ref_regs[`NBLINES_ADDR] = 16'(`NBLINES_RST);
        ref_regs[`LED1_ADDR]    = 16'(`LED1_RST);
        ref_regs[`LED2_ADDR]    = 16'(`LED2_RST);
        ref_regs[`LED3_ADDR]    = 16'(`LED3_RST);
        ref_regs[`VERSION_ADDR] = 16'(`VERSION_VAL);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < ROWS; i++) begin
            case (ROW_TABLE[i].op)
                OP_WR:   do_write(ROW_TABLE[i].addr, ROW_TABLE[i].data);
                OP_RD:   do_read(ROW_TABLE[i].addr, ROW_TABLE[i].exp_val, READ_LATENCY);
                OP_RDG: begin
                    do_read(ROW_TABLE[i].addr, ROW_TABLE[i].exp_val, GAIN_READ_LATENCY);
                    check_gain_port(ROW_TABLE[i].addr);
                end
                OP_EXT:  do_ext_start();
                default: set_status(ROW_TABLE[i].addr, ROW_TABLE[i].data);
            endcase
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // Watchdog allows ten clock periods per table row
    initial begin
        #(ROWS * 10 * PERIOD);
        abort_run("Timeout: the stimulus table did not finish in time");
    end

endmodule

// ==== build.f ====
+incdir+source
+incdir+verif
source/csr_pkg.sv
source/csr_req_if.sv
source/csr_addr_decoder.sv
source/csr_reg_bank.sv
source/dac_gain_table.sv
source/csr_read_return.sv
source/csr_top.sv
verif/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_block

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/csr_req_if.sv
      - source/csr_addr_decoder.sv
      - source/csr_reg_bank.sv
      - source/dac_gain_table.sv
      - source/csr_read_return.sv
      - source/csr_top.sv
  - target: test
    include_dirs:
      - source
      - verif
    files:
      - verif/csr_tb.sv
